/* rtl/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`default_nettype none

// datapath widths
`define WORD_W   16            // data and address
`define INSTR_W  18            // instruction word
`define REG_AW   4             // register address
`define REG_CNT  16            // sixteen GPRs
`define OPC_W    6
`define IMM_W    4             // short immediate, also branch offset
`define JMP_W    12            // absolute jump field

`define RESET_PC 16'd0         // first fetch after reset

// instruction field positions
`define OPC_HI   17
`define OPC_LO   12
`define RS_HI    11
`define RS_LO    8
`define RT_HI    7
`define RT_LO    4
`define IMM_HI   3            // imm and rd share these bits
`define IMM_LO   0
`define JMP_HI   11
`define JMP_LO   0

`default_nettype wire

`endif

/* rtl/cpuPkg.sv */
`include "cpu_consts.svh"
`default_nettype none

package cpuPkg;

	////////////////////
	// instruction set
	////////////////////

	// primary opcode, bits 17:12 of the instruction word
	typedef enum logic [`OPC_W-1:0] {
		opNop = '0,             // all-zero word doubles as the pipeline bubble
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opSlt,                  // signed compare, result is 0 or 1
		opAddi,                 // rt = rs + zext(imm)
		opLw,                   // rt = mem[rs + zext(imm)]
		opSw,                   // mem[rs + zext(imm)] = rt
		opBeq,                  // resolved in decode
		opJ                     // 12-bit absolute, taken in fetch
	} opcodeT;

	////////////////////
	// datapath selects
	////////////////////

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt
	} aluOpT;

	// operand source for execute and for the branch comparator
	typedef enum logic [1:0] {
		fromReg,                // register file value, no hazard
		fromMem,                // alu result sitting in memory stage
		fromWb                  // value being written back
	} fwdSelT;

	typedef enum logic {
		aluResult,
		memData                 // marks a load for the hazard unit
	} wbSelT;

endpackage

`default_nettype wire

/* rtl/fetchUnit.sv */
`include "cpu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module fetchUnit (
	input  logic                clk,
	input  logic                rstN,
	input  logic                stallF,        // hold pc on hazard
	input  logic [`INSTR_W-1:0] instr,         // imem word at pc, same cycle
	input  logic                branchTaken,   // from decode comparator
	input  logic [`WORD_W-1:0]  branchTarget,
	output logic [`WORD_W-1:0]  pc,
	output logic [`WORD_W-1:0]  pcPlus1
);
	import cpuPkg::*;

	logic [`WORD_W-1:0] jumpTarget;
	logic [`WORD_W-1:0] pcNext;
	logic               isJump;

	assign pcPlus1 = pc + 1'b1;

	// jump is spotted on the raw fetched word, so it costs no cycle
	assign isJump     = (instr[`OPC_HI:`OPC_LO] == opJ);
	assign jumpTarget = {{(`WORD_W-`JMP_W){1'b0}}, instr[`JMP_HI:`JMP_LO]}; // zero extend

	// taken branch wins, its fetch slot is squashed anyway
	always_comb begin
		if (branchTaken)
			pcNext = branchTarget;
		else if (isJump)
			pcNext = jumpTarget;
		else
			pcNext = pcPlus1;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= `RESET_PC;
		else if (!stallF)
			pc <= pcNext;              // stall refetches the same word
	end

endmodule

`default_nettype wire

/* rtl/decodeStage.sv */
`include "cpu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
	input  logic                clk,
	input  logic                rstN,
	input  logic                stallD,
	input  logic [`INSTR_W-1:0] instrF,
	input  logic [`WORD_W-1:0]  pcPlus1F,
	input  logic [`WORD_W-1:0]  rd1,            // regfile port 1, write-through
	input  logic [`WORD_W-1:0]  rd2,
	input  logic [`WORD_W-1:0]  memAluResult,   // forward source for the comparator
	input  cpuPkg::fwdSelT      fwdBr1,
	input  cpuPkg::fwdSelT      fwdBr2,
	output logic [`REG_AW-1:0]  ra1,            // rs
	output logic [`REG_AW-1:0]  ra2,            // rt
	output logic                branchTaken,
	output logic [`WORD_W-1:0]  branchTarget,
	output cpuPkg::opcodeT      opD,
	output logic [`WORD_W-1:0]  immExtD,        // zero extended
	output logic [`REG_AW-1:0]  destD,          // rd field, execute picks rt where needed
	output cpuPkg::aluOpT       aluOpD,
	output logic                aluSrcD,        // 1 selects the immediate
	output logic                regWeD,
	output logic                memWeD,
	output cpuPkg::wbSelT       wbSelD,
	output logic                isBranchD
);
	import cpuPkg::*;

	logic [`INSTR_W-1:0] instrD;
	logic [`WORD_W-1:0]  pcPlus1D;
	logic [`IMM_W-1:0]   immD;
	logic [`WORD_W-1:0]  cmpA;
	logic [`WORD_W-1:0]  cmpB;

	////////////////////
	// fetch/decode register
	////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			instrD   <= '0;                // zero word is a NOP
			pcPlus1D <= '0;
		end else if (branchTaken) begin
			instrD   <= '0;                // squash the wrong-path fetch
			pcPlus1D <= '0;
		end else if (!stallD) begin
			instrD   <= instrF;
			pcPlus1D <= pcPlus1F;
		end
	end

	// field split
	assign opD     = opcodeT'(instrD[`OPC_HI:`OPC_LO]);
	assign ra1     = instrD[`RS_HI:`RS_LO];
	assign ra2     = instrD[`RT_HI:`RT_LO];
	assign immD    = instrD[`IMM_HI:`IMM_LO];
	assign destD   = immD;
	assign immExtD = {{(`WORD_W-`IMM_W){1'b0}}, immD};

	////////////////////
	// control decode
	////////////////////

	always_comb begin
		aluOpD    = aluAdd;              // address calc for lw/sw too
		aluSrcD   = 1'b0;
		regWeD    = 1'b0;
		memWeD    = 1'b0;
		wbSelD    = aluResult;
		isBranchD = 1'b0;
		case (opD)
			opAdd:  regWeD = 1'b1;
			opSub: begin
				regWeD = 1'b1;
				aluOpD = aluSub;
			end
			opAnd: begin
				regWeD = 1'b1;
				aluOpD = aluAnd;
			end
			opOr: begin
				regWeD = 1'b1;
				aluOpD = aluOr;
			end
			opXor: begin
				regWeD = 1'b1;
				aluOpD = aluXor;
			end
			opSlt: begin
				regWeD = 1'b1;
				aluOpD = aluSlt;
			end
			opAddi: begin
				regWeD  = 1'b1;
				aluSrcD = 1'b1;
			end
			opLw: begin
				regWeD  = 1'b1;
				aluSrcD = 1'b1;
				wbSelD  = memData;
			end
			opSw: begin
				memWeD  = 1'b1;
				aluSrcD = 1'b1;
			end
			opBeq:  isBranchD = 1'b1;
			default: ;                     // nop, j and unused codes do nothing here
		endcase
	end

	////////////////////
	// branch resolve
	////////////////////

	assign cmpA = (fwdBr1 == fromMem) ? memAluResult : rd1;
	assign cmpB = (fwdBr2 == fromMem) ? memAluResult : rd2;

	// operands not ready while stalled, so no decision yet
	assign branchTaken  = isBranchD && (cmpA == cmpB) && !stallD;
	assign branchTarget = pcPlus1D + {{(`WORD_W-`IMM_W){immD[`IMM_W-1]}}, immD}; // signed offset

endmodule

`default_nettype wire

/* rtl/regFile.sv */
`include "cpu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input  logic               clk,
	input  logic               rstN,
	input  logic [`REG_AW-1:0] ra1,
	input  logic [`REG_AW-1:0] ra2,
	input  logic [`REG_AW-1:0] wa,           // write-back address
	input  logic [`WORD_W-1:0] wd,
	input  logic               we,
	output logic [`WORD_W-1:0] rd1,
	output logic [`WORD_W-1:0] rd2
);

	logic [`WORD_W-1:0] regs [`REG_CNT];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;           // all registers read zero out of reset
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// write-through, decode sees the value written back this cycle
	assign rd1 = (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

/* rtl/executeStage.sv */
`include "cpu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module executeStage (
	input  logic               clk,
	input  logic               rstN,
	input  logic               flushE,         // bubble in on stall
	input  logic [`REG_AW-1:0] ra1,
	input  logic [`REG_AW-1:0] ra2,
	input  cpuPkg::opcodeT     opD,
	input  logic [`WORD_W-1:0] immExtD,
	input  logic [`REG_AW-1:0] destD,
	input  cpuPkg::aluOpT      aluOpD,
	input  logic               aluSrcD,
	input  logic               regWeD,
	input  logic               memWeD,
	input  cpuPkg::wbSelT      wbSelD,
	input  logic [`WORD_W-1:0] rd1,
	input  logic [`WORD_W-1:0] rd2,
	input  cpuPkg::fwdSelT     fwdA,
	input  cpuPkg::fwdSelT     fwdB,
	input  logic [`WORD_W-1:0] memAluResult,
	input  logic [`WORD_W-1:0] wbData,
	output logic [`REG_AW-1:0] rsE,
	output logic [`REG_AW-1:0] rtE,
	output logic [`REG_AW-1:0] destE,
	output logic               regWeE,
	output cpuPkg::wbSelT      wbSelE,
	output logic [`WORD_W-1:0] aluResultE,
	output logic [`WORD_W-1:0] storeDataE,
	output logic               memWeE
);
	import cpuPkg::*;

	opcodeT             opE;
	aluOpT              aluOpE;
	logic               aluSrcE;
	logic [`WORD_W-1:0] rd1E;
	logic [`WORD_W-1:0] rd2E;
	logic [`WORD_W-1:0] immE;
	logic [`REG_AW-1:0] rdE;
	logic [`WORD_W-1:0] srcA;
	logic [`WORD_W-1:0] srcB;

	////////////////////
	// decode/execute register
	////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			opE     <= opNop;
			aluOpE  <= aluAdd;
			aluSrcE <= 1'b0;
			regWeE  <= 1'b0;
			memWeE  <= 1'b0;
			wbSelE  <= aluResult;
		end else if (flushE) begin
			opE     <= opNop;              // bubble, no side effects downstream
			aluOpE  <= aluAdd;
			aluSrcE <= 1'b0;
			regWeE  <= 1'b0;
			memWeE  <= 1'b0;
			wbSelE  <= aluResult;
		end else begin
			opE     <= opD;
			aluOpE  <= aluOpD;
			aluSrcE <= aluSrcD;
			regWeE  <= regWeD;
			memWeE  <= memWeD;
			wbSelE  <= wbSelD;
		end
	end

	always_ff @(posedge clk) begin
		rd1E <= rd1;
		rd2E <= rd2;
		immE <= immExtD;
		rsE  <= ra1;
		rtE  <= ra2;
		rdE  <= destD;
	end

	// operand forwarding, memory stage is the newer value
	always_comb begin
		case (fwdA)
			fromMem: srcA = memAluResult;
			fromWb:  srcA = wbData;
			default: srcA = rd1E;
		endcase
		case (fwdB)
			fromMem: storeDataE = memAluResult;
			fromWb:  storeDataE = wbData;
			default: storeDataE = rd2E;
		endcase
	end

	assign srcB = aluSrcE ? immE : storeDataE;   // rt value doubles as sw data

	////////////////////
	// alu
	////////////////////

	always_comb begin
		case (aluOpE)
			aluSub:  aluResultE = srcA - srcB;
			aluAnd:  aluResultE = srcA & srcB;
			aluOr:   aluResultE = srcA | srcB;
			aluXor:  aluResultE = srcA ^ srcB;
			aluSlt:  aluResultE = {{(`WORD_W-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			default: aluResultE = srcA + srcB;
		endcase
	end

	// addi and lw write rt, register ops write the rd field
	assign destE = (opE == opAddi || opE == opLw) ? rtE : rdE;

endmodule

`default_nettype wire

/* rtl/memWbStage.sv */
`include "cpu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module memWbStage (
	input  logic               clk,
	input  logic               rstN,
	input  logic [`WORD_W-1:0] aluResultE,
	input  logic [`WORD_W-1:0] storeDataE,
	input  logic [`REG_AW-1:0] destE,
	input  logic               regWeE,
	input  logic               memWeE,
	input  cpuPkg::wbSelT      wbSelE,
	input  logic [`WORD_W-1:0] dmemRdData,     // combinational read of dmemAddr
	output logic [`WORD_W-1:0] dmemAddr,
	output logic [`WORD_W-1:0] dmemWrData,
	output logic               dmemWe,         // single-cycle strobe
	output logic [`WORD_W-1:0] memAluResult,
	output logic [`REG_AW-1:0] destM,
	output logic               regWeM,
	output cpuPkg::wbSelT      wbSelM,
	output logic [`WORD_W-1:0] wbData,
	output logic [`REG_AW-1:0] wbAddr,
	output logic               wbWe
);
	import cpuPkg::*;

	logic [`WORD_W-1:0] aluResultM;
	logic [`WORD_W-1:0] storeDataM;
	logic [`WORD_W-1:0] aluResultW;
	logic [`WORD_W-1:0] loadDataW;
	wbSelT              wbSelW;

	// execute/memory and memory/write-back control
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			regWeM <= 1'b0;
			dmemWe <= 1'b0;
			wbSelM <= aluResult;
			wbWe   <= 1'b0;
			wbSelW <= aluResult;
		end else begin
			regWeM <= regWeE;
			dmemWe <= memWeE;                // strobe lives exactly one cycle per sw
			wbSelM <= wbSelE;
			wbWe   <= regWeM;
			wbSelW <= wbSelM;
		end
	end

	always_ff @(posedge clk) begin
		aluResultM <= aluResultE;
		storeDataM <= storeDataE;
		destM      <= destE;
		aluResultW <= aluResultM;
		loadDataW  <= dmemRdData;          // capture load data at end of memory stage
		wbAddr     <= destM;
	end

	assign dmemAddr     = aluResultM;
	assign dmemWrData   = storeDataM;
	assign memAluResult = aluResultM;      // forward tap, not valid for loads

	assign wbData = (wbSelW == memData) ? loadDataW : aluResultW;

endmodule

`default_nettype wire

/* rtl/hazardUnit.sv */
`include "cpu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
	input  logic               isBranchD,
	input  logic [`REG_AW-1:0] ra1,            // decode sources
	input  logic [`REG_AW-1:0] ra2,
	input  logic [`REG_AW-1:0] rsE,            // execute sources
	input  logic [`REG_AW-1:0] rtE,
	input  logic [`REG_AW-1:0] destE,
	input  logic               regWeE,
	input  cpuPkg::wbSelT      wbSelE,
	input  logic [`REG_AW-1:0] destM,
	input  logic               regWeM,
	input  cpuPkg::wbSelT      wbSelM,
	input  logic [`REG_AW-1:0] wbAddr,
	input  logic               wbWe,
	output cpuPkg::fwdSelT     fwdA,
	output cpuPkg::fwdSelT     fwdB,
	output cpuPkg::fwdSelT     fwdBr1,
	output cpuPkg::fwdSelT     fwdBr2,
	output logic               stallF,
	output logic               stallD,
	output logic               flushE
);
	import cpuPkg::*;

	logic hitE;           // instr in execute writes a decode source
	logic hitM;           // same for memory stage
	logic lwStall;
	logic brStall;

	////////////////////
	// forwarding
	////////////////////

	// memory stage is younger than write-back, so it wins
	assign fwdA = (regWeM && destM == rsE) ? fromMem :
		(wbWe && wbAddr == rsE) ? fromWb : fromReg;
	assign fwdB = (regWeM && destM == rtE) ? fromMem :
		(wbWe && wbAddr == rtE) ? fromWb : fromReg;

	// comparator only taps memory, write-back goes through regfile write-through
	assign fwdBr1 = (regWeM && destM == ra1) ? fromMem : fromReg;
	assign fwdBr2 = (regWeM && destM == ra2) ? fromMem : fromReg;

	////////////////////
	// stalls
	////////////////////

	assign hitE = regWeE && (destE == ra1 || destE == ra2);
	assign hitM = regWeM && (destM == ra1 || destM == ra2);

	assign lwStall = hitE && (wbSelE == memData);    // load-use, one bubble
	// branch waits for a result still in execute, or a load still in memory
	assign brStall = isBranchD && (hitE || (hitM && wbSelM == memData));

	assign stallF = lwStall || brStall;
	assign stallD = lwStall || brStall;
	assign flushE = lwStall || brStall;    // held decode instr must not also issue

endmodule

`default_nettype wire

/* rtl/pipeCpu.sv */
`include "cpu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module pipeCpu (
	input  logic                clk,
	input  logic                rstN,
	output logic [`WORD_W-1:0]  imemAddr,
	input  logic [`INSTR_W-1:0] imemData,     // combinational imem read
	output logic [`WORD_W-1:0]  dmemAddr,
	output logic [`WORD_W-1:0]  dmemWrData,
	output logic                dmemWe,
	input  logic [`WORD_W-1:0]  dmemRdData
);
	import cpuPkg::*;

	// fetch <-> decode
	logic [`WORD_W-1:0] pcPlus1F;
	logic               branchTaken;
	logic [`WORD_W-1:0] branchTarget;

	// decode outputs
	logic [`REG_AW-1:0] ra1;
	logic [`REG_AW-1:0] ra2;
	logic [`WORD_W-1:0] rd1;
	logic [`WORD_W-1:0] rd2;
	opcodeT             opD;
	logic [`WORD_W-1:0] immExtD;
	logic [`REG_AW-1:0] destD;
	aluOpT              aluOpD;
	logic               aluSrcD;
	logic               regWeD;
	logic               memWeD;
	wbSelT              wbSelD;
	logic               isBranchD;

	// execute outputs
	logic [`REG_AW-1:0] rsE;
	logic [`REG_AW-1:0] rtE;
	logic [`REG_AW-1:0] destE;
	logic               regWeE;
	wbSelT              wbSelE;
	logic [`WORD_W-1:0] aluResultE;
	logic [`WORD_W-1:0] storeDataE;
	logic               memWeE;

	// memory / write-back
	logic [`WORD_W-1:0] memAluResult;
	logic [`REG_AW-1:0] destM;
	logic               regWeM;
	wbSelT              wbSelM;
	logic [`WORD_W-1:0] wbData;
	logic [`REG_AW-1:0] wbAddr;
	logic               wbWe;

	// hazard controls
	fwdSelT fwdA;
	fwdSelT fwdB;
	fwdSelT fwdBr1;
	fwdSelT fwdBr2;
	logic   stallF;
	logic   stallD;
	logic   flushE;

	fetchUnit uFetch (
		.clk(clk), .rstN(rstN), .stallF(stallF), .instr(imemData),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.pc(imemAddr), .pcPlus1(pcPlus1F)
	);

	decodeStage uDecode (
		.clk(clk), .rstN(rstN), .stallD(stallD), .instrF(imemData), .pcPlus1F(pcPlus1F),
		.rd1(rd1), .rd2(rd2), .memAluResult(memAluResult), .fwdBr1(fwdBr1), .fwdBr2(fwdBr2),
		.ra1(ra1), .ra2(ra2), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.opD(opD), .immExtD(immExtD), .destD(destD), .aluOpD(aluOpD), .aluSrcD(aluSrcD),
		.regWeD(regWeD), .memWeD(memWeD), .wbSelD(wbSelD), .isBranchD(isBranchD)
	);

	regFile uRegs (
		.clk(clk), .rstN(rstN), .ra1(ra1), .ra2(ra2),
		.wa(wbAddr), .wd(wbData), .we(wbWe), .rd1(rd1), .rd2(rd2)
	);

	executeStage uExec (
		.clk(clk), .rstN(rstN), .flushE(flushE), .ra1(ra1), .ra2(ra2), .opD(opD),
		.immExtD(immExtD), .destD(destD), .aluOpD(aluOpD), .aluSrcD(aluSrcD),
		.regWeD(regWeD), .memWeD(memWeD), .wbSelD(wbSelD), .rd1(rd1), .rd2(rd2),
		.fwdA(fwdA), .fwdB(fwdB), .memAluResult(memAluResult), .wbData(wbData),
		.rsE(rsE), .rtE(rtE), .destE(destE), .regWeE(regWeE), .wbSelE(wbSelE),
		.aluResultE(aluResultE), .storeDataE(storeDataE), .memWeE(memWeE)
	);

	memWbStage uMemWb (
		.clk(clk), .rstN(rstN), .aluResultE(aluResultE), .storeDataE(storeDataE),
		.destE(destE), .regWeE(regWeE), .memWeE(memWeE), .wbSelE(wbSelE),
		.dmemRdData(dmemRdData), .dmemAddr(dmemAddr), .dmemWrData(dmemWrData),
		.dmemWe(dmemWe), .memAluResult(memAluResult), .destM(destM), .regWeM(regWeM),
		.wbSelM(wbSelM), .wbData(wbData), .wbAddr(wbAddr), .wbWe(wbWe)
	);

	hazardUnit uHazard (
		.isBranchD(isBranchD), .ra1(ra1), .ra2(ra2), .rsE(rsE), .rtE(rtE),
		.destE(destE), .regWeE(regWeE), .wbSelE(wbSelE),
		.destM(destM), .regWeM(regWeM), .wbSelM(wbSelM), .wbAddr(wbAddr), .wbWe(wbWe),
		.fwdA(fwdA), .fwdB(fwdB), .fwdBr1(fwdBr1), .fwdBr2(fwdBr2),
		.stallF(stallF), .stallD(stallD), .flushE(flushE)
	);

endmodule

`default_nettype wire

/* verif/pipeCpu_tb.sv */
`include "cpu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module pipeCpu_tb;
	import cpuPkg::*;

	localparam int IMEM_DEPTH = 4096;         // covers the 12-bit jump range
	localparam int DMEM_DEPTH = 65536;        // full 16-bit data space
	localparam int MARK_ADDR  = 15;           // end-of-test marker location

	logic                clk;
	logic                rstN;
	logic [`WORD_W-1:0]  imemAddr;
	logic [`INSTR_W-1:0] imemData;
	logic [`WORD_W-1:0]  dmemAddr;
	logic [`WORD_W-1:0]  dmemWrData;
	logic                dmemWe;
	logic [`WORD_W-1:0]  dmemRdData;

	logic [`INSTR_W-1:0] imem [IMEM_DEPTH];
	logic [`WORD_W-1:0]  dmem [DMEM_DEPTH];
	logic [`WORD_W-1:0]  modelMem [DMEM_DEPTH]; // reference copy of data memory

	logic [31:0] expStores [$];               // {address, data} in program order
	logic        headValid;
	logic [`WORD_W-1:0] headAddr;
	logic [`WORD_W-1:0] headData;

	integer seed;
	logic [31:0] rnd;
	int asmPc;
	int asmEnd;
	int modelSteps;
	int storeIdx;
	int errCount;
	int testErrBase;
	int testsPassed;
	int testsTotal;
	int cycles;
	int cycleLimit;
	logic timedOut;
	string testNames [6];

	pipeCpu UUT (
		.clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWe(dmemWe),
		.dmemRdData(dmemRdData)
	);

	always #5 clk = ~clk;                      // 10 ns period

	////////////////////
	// memory models
	////////////////////

	assign imemData   = (imemAddr < IMEM_DEPTH) ? imem[imemAddr[11:0]] : '0; // past end reads nop
	assign dmemRdData = dmem[dmemAddr];

	always @(posedge clk) begin
		if (dmemWe)
			dmem[dmemAddr] <= dmemWrData;
	end

	////////////////////
	// program assembly
	////////////////////

	// three 4-bit fields, the last one is imm or rd
	function automatic logic [`INSTR_W-1:0] enc(input opcodeT op, input int a, input int b,
		input int c);
		return {op, 4'(a), 4'(b), 4'(c)};
	endfunction

	function automatic logic [`INSTR_W-1:0] encJ(input int target);
		return {opJ, 12'(target)};
	endfunction

	task automatic emit(input logic [`INSTR_W-1:0] w);
		imem[asmPc] = w;
		asmPc++;
	endtask

	// r14 = n, then store it at the marker address
	task automatic mark(input int n);
		emit(enc(opAddi, 0, 14, n));
		emit(enc(opSw, 0, 14, MARK_ADDR));
	endtask

	task automatic buildProgram();
		int loopPc;
		for (int i = 0; i < IMEM_DEPTH; i++)
			imem[i] = '0;
		asmPc = 0;
		mark(1);                             // reset: first store must be this one
		// dependent chains
		emit(enc(opAddi, 0, 1, 5));          // r1 = 5
		emit(enc(opAddi, 1, 2, 3));          // r2 = r1 + 3, distance 1
		emit(enc(opAdd, 1, 2, 3));           // r3 = r1 + r2, distances 2 and 1
		emit(enc(opXor, 1, 3, 4));           // r1 at distance 3, via regfile
		emit(enc(opSub, 4, 2, 5));           // r5 = r4 - r2
		emit(enc(opAnd, 5, 3, 6));
		emit(enc(opOr, 4, 6, 7));
		emit(enc(opSub, 0, 1, 10));          // r10 = -5
		emit(enc(opSlt, 7, 10, 8));          // positive < negative, signed -> 0
		emit(enc(opAddi, 8, 9, 9));
		emit(enc(opSlt, 10, 7, 11));         // -5 < r7 -> 1
		for (int r = 11; r >= 2; r--)
			emit(enc(opSw, 0, r, r - 2));    // first store picks r11 at distance 1
		mark(2);
		// loads
		emit(enc(opAddi, 0, 12, 8));
		emit(enc(opAdd, 12, 12, 12));
		emit(enc(opAdd, 12, 12, 12));        // r12 = 32, base for preloaded words
		emit(enc(opLw, 12, 1, 0));
		emit(enc(opAdd, 1, 1, 2));           // load-use
		emit(enc(opSw, 0, 2, 0));
		emit(enc(opLw, 12, 3, 1));
		emit(enc(opSw, 0, 3, 1));            // load feeds store data
		emit(enc(opLw, 12, 4, 2));
		emit(enc(opAddi, 4, 5, 1));
		emit(enc(opSw, 0, 5, 2));
		emit(enc(opLw, 0, 6, 0));            // reads back a word stored above
		emit(enc(opSw, 0, 6, 3));
		mark(3);
		// branches
		emit(enc(opAddi, 0, 1, 7));
		emit(enc(opAddi, 0, 2, 7));
		emit(enc(opBeq, 1, 2, 1));           // taken, r2 still in execute
		emit(enc(opSw, 0, 1, 4));            // must never appear
		emit(enc(opSw, 0, 2, 5));
		emit(enc(opAddi, 0, 3, 2));
		emit(enc(opBeq, 3, 1, 1));           // not taken
		emit(enc(opSw, 0, 3, 6));
		emit(enc(opSw, 0, 1, 7));
		emit(enc(opLw, 0, 4, 7));
		emit(enc(opBeq, 4, 1, 1));           // taken, operand from a load
		emit(enc(opSw, 0, 4, 8));            // squashed
		emit(enc(opSw, 0, 4, 9));
		emit(enc(opLw, 12, 5, 3));           // random word
		emit(enc(opBeq, 5, 0, 1));
		emit(enc(opSw, 0, 5, 10));
		emit(enc(opAnd, 0, 0, 6));           // r6 = 0
		emit(enc(opAddi, 0, 7, 3));
		emit(enc(opBeq, 6, 0, 1));           // taken, r6 forwarded from memory
		emit(enc(opSw, 0, 7, 11));
		emit(enc(opSw, 0, 7, 12));
		mark(4);
		// countdown loop, then a jump over a block of stores
		emit(enc(opAddi, 0, 2, 5));          // count
		emit(enc(opAddi, 0, 1, 1));
		emit(enc(opAnd, 0, 0, 13));          // iteration counter
		loopPc = asmPc;
		emit(enc(opAddi, 13, 13, 1));
		emit(enc(opSub, 2, 1, 2));
		emit(enc(opBeq, 2, 0, 1));           // exit at zero
		emit(enc(opBeq, 0, 0, loopPc - (asmPc + 1))); // always taken, backward
		emit(enc(opSw, 0, 13, 11));
		emit(enc(opSw, 0, 2, 12));           // final count
		emit(encJ(asmPc + 4));
		emit(enc(opSw, 0, 13, 13));          // skipped block
		emit(enc(opSw, 0, 13, 14));
		emit(enc(opSw, 0, 2, 13));
		mark(5);
		asmEnd = asmPc;
	endtask

	////////////////////
	// reference model
	////////////////////

	// runs the program one instruction at a time, records every store
	task automatic runModel();
		logic [`WORD_W-1:0]  regs [`REG_CNT];
		logic [`WORD_W-1:0]  pc;
		logic [`WORD_W-1:0]  a;
		logic [`WORD_W-1:0]  b;
		logic [`WORD_W-1:0]  ea;
		logic [`INSTR_W-1:0] w;
		logic [3:0]          rs;
		logic [3:0]          rt;
		logic [3:0]          f;
		for (int i = 0; i < `REG_CNT; i++)
			regs[i] = '0;
		pc = `RESET_PC;
		modelSteps = 0;
		while (int'(pc) != asmEnd && modelSteps < 1000) begin
			w  = imem[pc[11:0]];
			rs = w[`RS_HI:`RS_LO];
			rt = w[`RT_HI:`RT_LO];
			f  = w[`IMM_HI:`IMM_LO];
			a  = regs[rs];
			b  = regs[rt];
			ea = a + {{(`WORD_W-`IMM_W){1'b0}}, f};
			pc = pc + 16'd1;
			case (w[`OPC_HI:`OPC_LO])
				opAdd:  regs[f] = a + b;
				opSub:  regs[f] = a - b;
				opAnd:  regs[f] = a & b;
				opOr:   regs[f] = a | b;
				opXor:  regs[f] = a ^ b;
				opSlt:  regs[f] = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
				opAddi: regs[rt] = ea;
				opLw:   regs[rt] = modelMem[ea];
				opSw: begin
					modelMem[ea] = b;
					expStores.push_back({ea, b});
				end
				opBeq: begin
					if (a == b)
						pc = pc + {{(`WORD_W-`IMM_W){f[3]}}, f}; // relative to pc+1
				end
				opJ:    pc = {4'b0, w[`JMP_HI:`JMP_LO]};
				default: ;
			endcase
			modelSteps++;
		end
	endtask

	////////////////////
	// store checking
	////////////////////

	task automatic loadHead();
		if (storeIdx < expStores.size()) begin
			headValid = 1'b1;
			headAddr  = expStores[storeIdx][31:16];
			headData  = expStores[storeIdx][15:0];
		end else begin
			headValid = 1'b0;                // no store left to come
			headAddr  = '0;
			headData  = '0;
		end
	endtask

	task automatic endTest(input logic [`WORD_W-1:0] n);
		string name;
		name = (n >= 1 && n <= 5) ? testNames[n[2:0]] : "unknown";
		if (errCount == testErrBase)
			testsPassed++;
		$display("test %0d (%s) finished at %0t ns: %s, %0d errors", n, name, $time,
			(errCount == testErrBase) ? "pass" : "fail", errCount - testErrBase);
		testErrBase = errCount;
	endtask

	// head moves on at the edge that performs the write
	always @(posedge clk) begin
		if (rstN && dmemWe) begin
			if (headValid && headAddr == MARK_ADDR)
				endTest(headData);
			storeIdx++;
			loadHead();
		end
	end

	// checks sample mid-cycle, everything is settled there
	resetQuiet: assert property (@(negedge clk) !rstN |-> !dmemWe)
		else begin
			errCount++;
			$display("Error at %0t ns: dmemWe got %b expected 0 in reset", $time, dmemWe);
		end

	resetPc: assert property (@(negedge clk) !rstN |-> imemAddr == `RESET_PC)
		else begin
			errCount++;
			$display("Error at %0t ns: imemAddr got %h expected %h in reset", $time,
				imemAddr, `RESET_PC);
		end

	noExtraStore: assert property (@(negedge clk) disable iff (!rstN) dmemWe |-> headValid)
		else begin
			errCount++;
			$display("unexpected data memory write at %0t ns, address %h data %h, none was due",
				$time, dmemAddr, dmemWrData);
		end

	storeAddr: assert property (@(negedge clk) disable iff (!rstN)
		(dmemWe && headValid) |-> dmemAddr == headAddr)
		else begin
			errCount++;
			$display("Error at %0t ns: dmemAddr got %h expected %h", $time, dmemAddr, headAddr);
		end

	storeData: assert property (@(negedge clk) disable iff (!rstN)
		(dmemWe && headValid) |-> dmemWrData == headData)
		else begin
			errCount++;
			$display("Error at %0t ns: dmemWrData got %h expected %h", $time, dmemWrData,
				headData);
		end

	////////////////////
	// main sequence
	////////////////////

	initial begin
		clk         = 1'b0;
		rstN        = 1'b0;
		seed        = 32'hb81e_f80f;
		errCount    = 0;
		testErrBase = 0;
		testsPassed = 0;
		testsTotal  = 0;
		timedOut    = 1'b0;
		testNames   = '{"", "reset", "forwarding chains", "load use", "branches",
			"loop and jump"};
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			rnd         = $random(seed);
			dmem[i]    <= rnd[`WORD_W-1:0];
			modelMem[i] = rnd[`WORD_W-1:0];  // model starts from the same image
		end
		buildProgram();
		runModel();
		foreach (expStores[i])
			if (expStores[i][31:16] == MARK_ADDR)
				testsTotal++;
		storeIdx = 0;
		loadHead();
		cycleLimit = 3 * modelSteps + 50;
		repeat (5) @(posedge clk);
		#1 rstN = 1'b1;
		@(negedge clk);
		firstFetch: assert (imemAddr == `RESET_PC)
			else begin
				errCount++;
				$display("Error at %0t ns: imemAddr got %h expected %h after reset", $time,
					imemAddr, `RESET_PC);
			end
		cycles = 0;
		while (storeIdx < expStores.size() && !timedOut) begin
			@(negedge clk);
			cycles++;
			if (cycles > cycleLimit)
				timedOut = 1'b1;
		end
		if (timedOut)
			$display("timeout after %0d cycles, only %0d of %0d expected stores seen",
				cycles, storeIdx, expStores.size());
		else
			repeat (10) @(negedge clk);      // a stray late store still trips the check
		$display("tests passed %0d of %0d, stores seen %0d of %0d, errors %0d",
			testsPassed, testsTotal, storeIdx, expStores.size(), errCount);
		if (errCount == 0 && !timedOut && testsPassed == testsTotal)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* pipeCpu.f */
+incdir+rtl
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/decodeStage.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/hazardUnit.sv
rtl/pipeCpu.sv
verif/pipeCpu_tb.sv

/* runSim.sh */
#!/usr/bin/env bash
# build and run the pipelined core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f pipeCpu.f --top-module pipeCpu_tb -Mdir obj_dir -o simv

./obj_dir/simv | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
